// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] data_t;

    // memory only decodes the low address bits
    localparam int MEM_ADDR_BITS = 18;

    localparam int INST_BYTES = 4;

    localparam logic [6:0] OPCODE_JAL = 7'b1101111;

    typedef struct packed {
        logic [24:0] fields;
        logic [6:0]  opcode;
    } base_fmt_t;

    // J-type immediate is scattered over the upper bits
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        base_fmt_t base_fmt;
        j_fmt_t    j_fmt;
    } inst_u;

endpackage

// ==== verilog/cpu_ifs.sv ====
`timescale 1ns/1ns

// fetch asks memory controller for one instruction word
interface mem_req_if;
    import cpu_pkg::*;

    logic  req;
    data_t addr;
    logic  ok;
    data_t word;

    modport fetch (output req, output addr, input ok, input word);
    modport ctrl (input req, input addr, output ok, output word);
endinterface

// lookup is combinational, fill is written on the clock edge
interface icache_if;
    import cpu_pkg::*;

    data_t lookup_addr;
    logic  hit;
    data_t hit_word;
    logic  fill_en;
    data_t fill_addr;
    data_t fill_word;

    modport fetch (
        output lookup_addr, output fill_en, output fill_addr, output fill_word,
        input  hit, input hit_word
    );
    modport cache (
        input  lookup_addr, input fill_en, input fill_addr, input fill_word,
        output hit, output hit_word
    );
endinterface

interface queue_push_if;
    import cpu_pkg::*;

    logic  push;
    data_t push_pc;
    data_t push_word;
    logic  full;

    modport fetch (output push, output push_pc, output push_word, input full);
    modport queue (input push, input push_pc, input push_word, output full);
endinterface

// ==== verilog/mem_ctrl.sv ====
`timescale 1ns/1ns

module mem_ctrl (
    input  logic           clk_in,
    input  logic           rst,
    input  logic           rdy,
    input  logic [7:0]     mem_din,
    output cpu_pkg::data_t mem_a,
    mem_req_if.ctrl        bus
);
    import cpu_pkg::*;

    logic        busy;
    logic [2:0]  cnt;
    logic [23:0] low_bytes;
    logic        capture;

    // cnt 0 only sends the first address, cnt 1..3 see bytes 0..2 on mem_din
    assign capture = busy && (cnt != 3'd0) && (cnt != INST_BYTES);

    // top byte is still on mem_din when ok goes high
    assign bus.ok   = busy && (cnt == INST_BYTES);
    assign bus.word = {mem_din, low_bytes};

    always_ff @(posedge clk_in) begin
        if (rst) begin
            busy  <= 1'b0;
            cnt   <= 3'd0;
            mem_a <= '0;
        end else if (rdy) begin
            if (!busy) begin
                if (bus.req) begin
                    busy  <= 1'b1;
                    cnt   <= 3'd0;
                    mem_a <= data_t'(bus.addr[MEM_ADDR_BITS-1:0]);
                end
            end else begin
                cnt <= cnt + 3'd1;
                // step through the word, stay on the last byte address
                if (cnt < INST_BYTES - 1) begin
                    mem_a[1:0] <= mem_a[1:0] + 2'd1;
                end
                if (cnt == INST_BYTES) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // little endian, each byte shifts in from the top
    always_ff @(posedge clk_in) begin
        if (rdy && capture) begin
            low_bytes <= {mem_din, low_bytes[23:8]};
        end
    end

endmodule

// ==== verilog/icache.sv ====
`timescale 1ns/1ns

module icache #(
    parameter int ICACHE_INDEX_BITS = 6
) (
    input  logic    clk_in,
    input  logic    rst,
    input  logic    rdy,
    icache_if.cache port
);
    import cpu_pkg::*;

    localparam int LINES    = 1 << ICACHE_INDEX_BITS;
    localparam int OFF_BITS = $clog2(INST_BYTES);
    localparam int TAG_BITS = $bits(data_t) - ICACHE_INDEX_BITS - OFF_BITS;

    logic [LINES-1:0]    valid;
    logic [TAG_BITS-1:0] tags [LINES];
    data_t               words [LINES];

    logic [ICACHE_INDEX_BITS-1:0] rd_idx;
    logic [TAG_BITS-1:0]          rd_tag;
    logic [ICACHE_INDEX_BITS-1:0] wr_idx;
    logic [TAG_BITS-1:0]          wr_tag;

    assign rd_idx = port.lookup_addr[OFF_BITS +: ICACHE_INDEX_BITS];
    assign rd_tag = port.lookup_addr[$bits(data_t)-1 -: TAG_BITS];
    assign wr_idx = port.fill_addr[OFF_BITS +: ICACHE_INDEX_BITS];
    assign wr_tag = port.fill_addr[$bits(data_t)-1 -: TAG_BITS];

    // zero latency lookup
    assign port.hit      = valid[rd_idx] && (tags[rd_idx] == rd_tag);
    assign port.hit_word = words[rd_idx];

    always_ff @(posedge clk_in) begin
        if (rst) begin
            valid <= '0;
        end else if (rdy && port.fill_en) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy && port.fill_en) begin
            tags[wr_idx]  <= wr_tag;
            words[wr_idx] <= port.fill_word;
        end
    end

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit (
    input  logic        clk_in,
    input  logic        rst,
    input  logic        rdy,
    icache_if.fetch     cache,
    mem_req_if.fetch    mem,
    queue_push_if.fetch queue
);
    import cpu_pkg::*;

    data_t pc;
    logic  mem_wait;
    inst_u cur_inst;
    logic  avail;
    logic  take;
    data_t jal_off;
    data_t next_pc;

    // memory return while waiting and the cache otherwise
    assign cur_inst = mem_wait ? mem.word : cache.hit_word;
    assign avail    = mem_wait ? mem.ok : cache.hit;
    assign take     = avail && !queue.full;

    assign jal_off = {{11{cur_inst.j_fmt.imm20}},
                      cur_inst.j_fmt.imm20,
                      cur_inst.j_fmt.imm19_12,
                      cur_inst.j_fmt.imm11,
                      cur_inst.j_fmt.imm10_1,
                      1'b0};

    // conditional branches fall through
    assign next_pc = (cur_inst.base_fmt.opcode == OPCODE_JAL) ? pc + jal_off : pc + INST_BYTES;

    assign cache.lookup_addr = pc;
    assign cache.fill_en     = mem_wait && mem.ok;
    assign cache.fill_addr   = pc;
    assign cache.fill_word   = mem.word;

    // req stays up for the whole memory access
    assign mem.req  = mem_wait;
    assign mem.addr = pc;

    assign queue.push      = take;
    assign queue.push_pc   = pc;
    assign queue.push_word = cur_inst;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            pc       <= '0;
            mem_wait <= 1'b0;
        end else if (rdy) begin
            if (take) begin
                pc <= next_pc;
            end
            if (mem_wait) begin
                // filled line keeps the word until the queue has room
                if (mem.ok) begin
                    mem_wait <= 1'b0;
                end
            end else if (!cache.hit && !queue.full) begin
                mem_wait <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/inst_queue.sv ====
`timescale 1ns/1ns

module inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic           clk_in,
    input  logic           rst,
    input  logic           rdy,
    queue_push_if.queue    in,
    output logic           ins_valid,
    output cpu_pkg::data_t ins_pc,
    output cpu_pkg::data_t ins_word,
    input  logic           ins_ready
);
    import cpu_pkg::*;

    localparam int PTR_BITS = $clog2(QUEUE_DEPTH);

    data_t pc_mem [QUEUE_DEPTH];
    data_t word_mem [QUEUE_DEPTH];

    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS:0]   count;
    logic                do_push;
    logic                do_pop;

    assign in.full   = (count == QUEUE_DEPTH);
    assign ins_valid = (count != '0);
    assign ins_pc    = pc_mem[rd_ptr];
    assign ins_word  = word_mem[rd_ptr];

    assign do_push = in.push && !in.full;
    assign do_pop  = ins_valid && ins_ready;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_in) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (rdy) begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy && do_push) begin
            pc_mem[wr_ptr]   <= in.push_pc;
            word_mem[wr_ptr] <= in.push_word;
        end
    end

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/1ns

module cpu #(
    parameter int ICACHE_INDEX_BITS = 6,
    parameter int QUEUE_DEPTH       = 4
) (
    input  logic           clk_in,
    input  logic           rst,
    input  logic           rdy,
    input  logic [7:0]     mem_din,
    output logic [7:0]     mem_dout,
    output cpu_pkg::data_t mem_a,
    output logic           mem_wr,
    output logic           ins_valid,
    output cpu_pkg::data_t ins_pc,
    output cpu_pkg::data_t ins_word,
    input  logic           ins_ready
);

    mem_req_if    mem_bus ();
    icache_if     cache_bus ();
    queue_push_if queue_bus ();

    // front end only reads memory
    assign mem_dout = 8'd0;
    assign mem_wr   = 1'b0;

    mem_ctrl u_mem_ctrl (
        .clk_in  (clk_in),
        .rst     (rst),
        .rdy     (rdy),
        .mem_din (mem_din),
        .mem_a   (mem_a),
        .bus     (mem_bus)
    );

    icache #(
        .ICACHE_INDEX_BITS (ICACHE_INDEX_BITS)
    ) u_icache (
        .clk_in (clk_in),
        .rst    (rst),
        .rdy    (rdy),
        .port   (cache_bus)
    );

    fetch_unit u_fetch_unit (
        .clk_in (clk_in),
        .rst    (rst),
        .rdy    (rdy),
        .cache  (cache_bus),
        .mem    (mem_bus),
        .queue  (queue_bus)
    );

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_inst_queue (
        .clk_in    (clk_in),
        .rst       (rst),
        .rdy       (rdy),
        .in        (queue_bus),
        .ins_valid (ins_valid),
        .ins_pc    (ins_pc),
        .ins_word  (ins_word),
        .ins_ready (ins_ready)
    );

endmodule

// ==== test/cpu_checker.sv ====
`timescale 1ns/1ns

module cpu_checker (
    input logic           clk_in,
    input logic           rst,
    input logic           rdy,
    input logic           mem_wr,
    input cpu_pkg::data_t mem_a,
    input logic           ins_valid,
    input cpu_pkg::data_t ins_pc,
    input cpu_pkg::data_t ins_word,
    input logic           ins_ready
);
    import cpu_pkg::*;

    int fail_count = 0;

    no_write: assert property (@(posedge clk_in) disable iff (rst) !mem_wr)
        else begin
            fail_count++;
            $error("mem_wr went high");
        end

    addr_range: assert property (@(posedge clk_in) disable iff (rst)
        mem_a[31:MEM_ADDR_BITS] == '0)
        else begin
            fail_count++;
            $error("mem_a has bits set above the memory range");
        end

    // entry waits on the ports until it is taken
    hold_until_taken: assert property (@(posedge clk_in) disable iff (rst)
        ins_valid && !(ins_ready && rdy) |=> ins_valid && $stable(ins_pc) && $stable(ins_word))
        else begin
            fail_count++;
            $error("issued instruction changed before it was taken");
        end

    empty_after_reset: assert property (@(posedge clk_in) rst |=> !ins_valid)
        else begin
            fail_count++;
            $error("ins_valid high in the cycle after reset");
        end

endmodule

bind cpu cpu_checker chk0 (
    .clk_in    (clk_in),
    .rst       (rst),
    .rdy       (rdy),
    .mem_wr    (mem_wr),
    .mem_a     (mem_a),
    .ins_valid (ins_valid),
    .ins_pc    (ins_pc),
    .ins_word  (ins_word),
    .ins_ready (ins_ready)
);

// ==== test/fetch_monitor.sv ====
`timescale 1ns/1ns

module fetch_monitor #(
    parameter int EXP_COUNT       = 17,
    parameter int LOOP_CHECK_FROM = 9
) (
    input  logic           clk_in,
    input  logic           rst,
    input  logic           rdy,
    input  logic           ins_valid,
    input  logic           ins_ready,
    input  cpu_pkg::data_t ins_pc,
    input  cpu_pkg::data_t ins_word,
    input  cpu_pkg::data_t mem_a,
    input  logic [7:0]     mem_dout,
    input  cpu_pkg::data_t exp_pc [EXP_COUNT],
    input  cpu_pkg::data_t exp_word [EXP_COUNT],
    output int             taken_count,
    output int             value_errors,
    output int             loop_reads
);
    import cpu_pkg::*;

    int    taken = 0;
    int    mismatches = 0;
    int    moved = 0;
    data_t last_mem_a = '0;

    assign taken_count  = taken;
    assign value_errors = mismatches;
    assign loop_reads   = moved;

    // sampled on the falling edge
    always @(negedge clk_in) begin
        if (rst) begin
            taken      = 0;
            last_mem_a = mem_a;
        end else begin
            // front end never writes data
            if (mem_dout !== 8'd0) begin
                mismatches = mismatches + 1;
                $display("Error at %0t ns: mem_dout is %h, expected 00", $time, mem_dout);
            end
            // passes 2 and 3 of the loop must come from the cache
            if (taken >= LOOP_CHECK_FROM && taken < EXP_COUNT && mem_a != last_mem_a) begin
                moved = moved + 1;
                $display("Error at %0t ns: mem_a moved to %h during a cached loop pass",
                         $time, mem_a);
            end
            last_mem_a = mem_a;
            if (rdy && ins_valid && ins_ready) begin
                if (taken >= EXP_COUNT) begin
                    mismatches = mismatches + 1;
                    $display("Error at %0t ns: extra instruction pc %h word %h taken",
                             $time, ins_pc, ins_word);
                end else if (ins_pc !== exp_pc[taken] || ins_word !== exp_word[taken]) begin
                    mismatches = mismatches + 1;
                    $display("Error at %0t ns: instruction %0d is pc %h word %h, expected %h %h",
                             $time, taken, ins_pc, ins_word, exp_pc[taken], exp_word[taken]);
                end
                taken = taken + 1;
            end
        end
    end

endmodule

// ==== test/tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu;
    import cpu_pkg::*;

    localparam int STRAIGHT_LEN = 5;
    localparam int LOOP_LEN     = 4;
    localparam int LOOP_PASSES  = 3;
    localparam int EXP_COUNT    = STRAIGHT_LEN + LOOP_LEN * LOOP_PASSES;
    localparam int MEM_BYTES    = 1 << MEM_ADDR_BITS;
    localparam int RESET_CYCLES = 5;

    // straight run with a beq that falls through, jal forward to 32, loop 32..44
    localparam int PROG_LEN = 12;
    localparam int PROG_ADDR [PROG_LEN] = '{0, 4, 8, 12, 16, 20, 24, 28, 32, 36, 40, 44};
    localparam data_t PROG_WORD [PROG_LEN] = '{
        32'h00100093, 32'h00200113, 32'h00300193, 32'h00000463,
        32'h010000ef, 32'hfff00f93, 32'hfff00f93, 32'hfff00f93,
        32'h00120213, 32'h004282b3, 32'h12345337, 32'hff5ff06f
    };

    // per phase rdy low %, ins_ready low % and ins_ready hold cycles
    localparam int NUM_PHASES = 5;
    localparam int RDY_LOW_PCT [NUM_PHASES]   = '{0, 40, 0, 0, 30};
    localparam int READY_LOW_PCT [NUM_PHASES] = '{0, 0, 60, 85, 50};
    localparam int READY_HOLD [NUM_PHASES]    = '{1, 1, 1, 6, 3};

    localparam int WATCHDOG_CYCLES = NUM_PHASES * EXP_COUNT * 12 + 200;

    logic       clk_in = 1'b0;
    logic       rst;
    logic       rdy;
    logic [7:0] mem_din = 8'd0;
    logic [7:0] mem_dout;
    data_t      mem_a;
    logic       mem_wr;
    logic       ins_valid;
    data_t      ins_pc;
    data_t      ins_word;
    logic       ins_ready;

    logic [7:0]               mem [MEM_BYTES];
    logic [MEM_ADDR_BITS-1:0] mem_addr_q;
    logic                     mem_rdy_q;

    data_t exp_pc [EXP_COUNT];
    data_t exp_word [EXP_COUNT];
    int    taken_count;
    int    value_errors;
    int    loop_reads;
    int    seed;
    int    phase;

    cpu #(
        .ICACHE_INDEX_BITS (6),
        .QUEUE_DEPTH       (4)
    ) dut0 (
        .clk_in    (clk_in),
        .rst       (rst),
        .rdy       (rdy),
        .mem_din   (mem_din),
        .mem_dout  (mem_dout),
        .mem_a     (mem_a),
        .mem_wr    (mem_wr),
        .ins_valid (ins_valid),
        .ins_pc    (ins_pc),
        .ins_word  (ins_word),
        .ins_ready (ins_ready)
    );

    fetch_monitor #(
        .EXP_COUNT       (EXP_COUNT),
        .LOOP_CHECK_FROM (STRAIGHT_LEN + LOOP_LEN)
    ) mon0 (
        .clk_in       (clk_in),
        .rst          (rst),
        .rdy          (rdy),
        .ins_valid    (ins_valid),
        .ins_ready    (ins_ready),
        .ins_pc       (ins_pc),
        .ins_word     (ins_word),
        .mem_a        (mem_a),
        .mem_dout     (mem_dout),
        .exp_pc       (exp_pc),
        .exp_word     (exp_word),
        .taken_count  (taken_count),
        .value_errors (value_errors),
        .loop_reads   (loop_reads)
    );

    always #10 clk_in = ~clk_in;

    // drive the byte at last cycle's address unless rdy was low
    always @(posedge clk_in) begin
        mem_addr_q = mem_a[MEM_ADDR_BITS-1:0];
        mem_rdy_q  = rdy;
        #2;
        if (mem_rdy_q) begin
            mem_din = mem[mem_addr_q];
        end
    end

    function automatic int rand_pct();
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'd100);
    endfunction

    function automatic data_t read_word(input data_t addr);
        int base;
        base = int'(addr[MEM_ADDR_BITS-1:0]);
        return {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
    endfunction

    task automatic load_program();
        int i;
        for (i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'(i ^ (i >> 8) ^ (i >> 16));
        end
        for (i = 0; i < PROG_LEN; i++) begin
            mem[PROG_ADDR[i]]     = PROG_WORD[i][7:0];
            mem[PROG_ADDR[i] + 1] = PROG_WORD[i][15:8];
            mem[PROG_ADDR[i] + 2] = PROG_WORD[i][23:16];
            mem[PROG_ADDR[i] + 3] = PROG_WORD[i][31:24];
        end
    endtask

    // walk the program with jal jumps and pc + 4 for everything else
    task automatic build_expected();
        int    i;
        data_t pc;
        inst_u inst;
        data_t offset;
        pc = '0;
        for (i = 0; i < EXP_COUNT; i++) begin
            inst        = read_word(pc);
            exp_pc[i]   = pc;
            exp_word[i] = inst;
            if (inst.base_fmt.opcode == OPCODE_JAL) begin
                offset = {{12{inst.j_fmt.imm20}}, inst.j_fmt.imm19_12, inst.j_fmt.imm11,
                          inst.j_fmt.imm10_1, 1'b0};
                pc = pc + offset;
            end else begin
                pc = pc + INST_BYTES;
            end
        end
    endtask

    task automatic apply_reset();
        rst       = 1'b1;
        rdy       = 1'b1;
        ins_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_in);
        #2;
        rst = 1'b0;
    endtask

    task automatic run_phase(input int p);
        int hold_left;
        hold_left = 0;
        while (taken_count < EXP_COUNT) begin
            if (hold_left == 0) begin
                ins_ready = (rand_pct() >= READY_LOW_PCT[p]);
                hold_left = READY_HOLD[p];
            end
            hold_left = hold_left - 1;
            rdy = (rand_pct() >= RDY_LOW_PCT[p]);
            @(posedge clk_in);
            #2;
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d wrong values, %0d loop memory reads, %0d assertion failures",
                 value_errors, loop_reads, dut0.chk0.fail_count);
    endtask

    initial begin
        seed      = 68;
        phase     = 0;
        rst       = 1'b1;
        rdy       = 1'b1;
        ins_ready = 1'b0;
        load_program();
        build_expected();
        for (phase = 0; phase < NUM_PHASES; phase++) begin
            apply_reset();
            run_phase(phase);
        end
        report_counts();
        if (value_errors + loop_reads + dut0.chk0.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("Timeout: no finish within %0d cycles, phase %0d had %0d of %0d instructions",
                 WATCHDOG_CYCLES, phase, taken_count, EXP_COUNT);
        report_counts();
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== src.f ====
verilog/cpu_pkg.sv
verilog/cpu_ifs.sv
verilog/mem_ctrl.sv
verilog/icache.sv
verilog/fetch_unit.sv
verilog/inst_queue.sv
verilog/cpu.sv
test/cpu_checker.sv
test/fetch_monitor.sv
test/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_cpu
FILELIST  := src.f
MDIR      := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation into $(LOG), check for pass"
	@echo "  clean  remove $(MDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)
	./$(MDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)
